// File: common/titan_defines.svh
`ifndef TITAN_DEFINES_SVH
`define TITAN_DEFINES_SVH

// datapath and address width
`define TITAN_XLEN 32

// instruction word width
`define TITAN_ILEN 32

// architectural registers, x0 included
`define TITAN_NREGS 32

// register address width
`define TITAN_RADDR_W 5

// shift amount width for RV32
`define TITAN_SHAMT_W 5

// ex_pc after reset
`define TITAN_RESET_PC 32'h0000_0000

// forwarding select width, 0 rf, 1 ex, 2 mem, 3 wb
`define TITAN_FWD_SEL_W 2

// size of a link offset added to pc for jumps
`define TITAN_LINK_OFFSET 32'd4

`endif

// File: common/titan_pkg.sv
`default_nettype none

`include "titan_defines.svh"

package titan_pkg;

	// RV32I major opcodes handled by this stage
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_op_e;

	// branch conditions, same code as funct3
	typedef enum logic [2:0] {
		CMP_EQ  = 3'b000,
		CMP_NE  = 3'b001,
		CMP_LT  = 3'b100,
		CMP_GE  = 3'b101,
		CMP_LTU = 3'b110,
		CMP_GEU = 3'b111
	} cmp_op_e;

	// one-hot access size
	typedef enum logic [2:0] {
		MEM_NONE = 3'b000,
		MEM_BYTE = 3'b001,
		MEM_HALF = 3'b010,
		MEM_WORD = 3'b100
	} mem_size_e;

	typedef struct packed {
		logic      read;
		logic      write;
		logic      uns;
		mem_size_e size;
	} mem_flags_t;

	typedef struct packed {
		logic [`TITAN_XLEN-1:0]    pc;
		logic [`TITAN_ILEN-1:0]    instruction;
		logic [`TITAN_XLEN-1:0]    port_a;
		logic [`TITAN_XLEN-1:0]    port_b;
		alu_op_e                   alu_op;
		logic [`TITAN_RADDR_W-1:0] waddr;
		logic                      we;
		logic [`TITAN_XLEN-1:0]    store_data;
		mem_flags_t                mem_flags;
		logic                      illegal;
	} idex_t;

endpackage

`default_nettype wire

// File: common/titan_dec_if.sv
`default_nettype none

`include "titan_defines.svh"

// decoded control bundle, decoder to operand logic
interface titan_dec_if;
	logic [`TITAN_RADDR_W-1:0] rs1;
	logic [`TITAN_RADDR_W-1:0] rs2;
	logic [`TITAN_RADDR_W-1:0] rd;
	logic                      we;
	logic [`TITAN_XLEN-1:0]    imm;
	titan_pkg::alu_op_e        alu_op;
	titan_pkg::cmp_op_e        cmp_op;
	logic                      porta_sel_pc;
	logic                      portb_sel_imm;
	logic                      shift_op;
	logic                      branch_op;
	logic                      jump_op;
	logic                      jalr_op;
	titan_pkg::mem_flags_t     mem_flags;
	logic                      illegal;

	modport dec (output rs1, rs2, rd, we, imm, alu_op, cmp_op, porta_sel_pc,
		portb_sel_imm, shift_op, branch_op, jump_op, jalr_op, mem_flags, illegal);

	modport stage (input rs1, rs2, rd, we, imm, alu_op, cmp_op, porta_sel_pc,
		portb_sel_imm, shift_op, branch_op, jump_op, jalr_op, mem_flags, illegal);
endinterface

`default_nettype wire

// File: common/titan_rf_if.sv
`default_nettype none

`include "titan_defines.svh"

// two read ports of the register file
interface titan_rf_if;
	logic [`TITAN_RADDR_W-1:0] raddr1;
	logic [`TITAN_RADDR_W-1:0] raddr2;
	logic [`TITAN_XLEN-1:0]    rdata1;
	logic [`TITAN_XLEN-1:0]    rdata2;

	// requester drives addresses
	modport req (output raddr1, raddr2, input rdata1, rdata2);

	// data comes back in the same cycle
	modport rf (input raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

// File: id_stage/titan_decoder.sv
`default_nettype none

`include "titan_defines.svh"

module titan_decoder (
	input wire [`TITAN_ILEN-1:0] id_instruction_i,
	titan_dec_if.dec             dec_o
);

	titan_pkg::opcode_e     opcode;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	logic [`TITAN_XLEN-1:0] imm_i;
	logic [`TITAN_XLEN-1:0] imm_s;
	logic [`TITAN_XLEN-1:0] imm_b;
	logic [`TITAN_XLEN-1:0] imm_u;
	logic [`TITAN_XLEN-1:0] imm_j;
	logic                   illegal;

	function automatic titan_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? titan_pkg::ALU_SUB : titan_pkg::ALU_ADD;
			3'b001:  return titan_pkg::ALU_SLL;
			3'b010:  return titan_pkg::ALU_SLT;
			3'b011:  return titan_pkg::ALU_SLTU;
			3'b100:  return titan_pkg::ALU_XOR;
			3'b101:  return alt ? titan_pkg::ALU_SRA : titan_pkg::ALU_SRL;
			3'b110:  return titan_pkg::ALU_OR;
			default: return titan_pkg::ALU_AND;
		endcase
	endfunction

	function automatic titan_pkg::mem_size_e mem_size(input logic [1:0] f3_lo);
		case (f3_lo)
			2'b00:   return titan_pkg::MEM_BYTE;
			2'b01:   return titan_pkg::MEM_HALF;
			2'b10:   return titan_pkg::MEM_WORD;
			default: return titan_pkg::MEM_NONE;
		endcase
	endfunction

	assign opcode = titan_pkg::opcode_e'(id_instruction_i[6:0]);
	assign funct3 = id_instruction_i[14:12];
	assign funct7 = id_instruction_i[31:25];

	// immediate formats, all sign extended
	assign imm_i = {{20{id_instruction_i[31]}}, id_instruction_i[31:20]};
	assign imm_s = {{20{id_instruction_i[31]}}, id_instruction_i[31:25], id_instruction_i[11:7]};
	assign imm_b = {{19{id_instruction_i[31]}}, id_instruction_i[31], id_instruction_i[7],
		id_instruction_i[30:25], id_instruction_i[11:8], 1'b0};
	assign imm_u = {id_instruction_i[31:12], 12'b0};
	assign imm_j = {{11{id_instruction_i[31]}}, id_instruction_i[31], id_instruction_i[19:12],
		id_instruction_i[20], id_instruction_i[30:21], 1'b0};

	assign dec_o.illegal = illegal;

	always_comb begin
		dec_o.rs1 = '0;
		dec_o.rs2 = '0;
		dec_o.rd = '0;
		dec_o.we = 1'b0;
		dec_o.imm = '0;
		dec_o.alu_op = titan_pkg::ALU_ADD;
		dec_o.cmp_op = titan_pkg::CMP_EQ;
		dec_o.porta_sel_pc = 1'b0;
		dec_o.portb_sel_imm = 1'b0;
		dec_o.shift_op = 1'b0;
		dec_o.branch_op = 1'b0;
		dec_o.jump_op = 1'b0;
		dec_o.jalr_op = 1'b0;
		dec_o.mem_flags = '0;
		illegal = 1'b0;
		case (opcode)
			// rs1 stays x0 so port a reads zero
			titan_pkg::OPC_LUI, titan_pkg::OPC_AUIPC: begin
				dec_o.rd = id_instruction_i[11:7];
				dec_o.we = 1'b1;
				dec_o.imm = imm_u;
				dec_o.portb_sel_imm = 1'b1;
				dec_o.porta_sel_pc = (opcode == titan_pkg::OPC_AUIPC);
			end
			titan_pkg::OPC_JAL, titan_pkg::OPC_JALR: begin
				dec_o.rd = id_instruction_i[11:7];
				dec_o.we = 1'b1;
				dec_o.porta_sel_pc = 1'b1;
				dec_o.jump_op = 1'b1;
				dec_o.jalr_op = (opcode == titan_pkg::OPC_JALR);
				dec_o.imm = dec_o.jalr_op ? imm_i : imm_j;
				dec_o.rs1 = dec_o.jalr_op ? id_instruction_i[19:15] : '0;
				illegal = dec_o.jalr_op && (funct3 != 3'b000);
			end
			titan_pkg::OPC_BRANCH: begin
				dec_o.rs1 = id_instruction_i[19:15];
				dec_o.rs2 = id_instruction_i[24:20];
				dec_o.imm = imm_b;
				dec_o.branch_op = 1'b1;
				dec_o.cmp_op = titan_pkg::cmp_op_e'(funct3);
				illegal = (funct3[2:1] == 2'b01);
			end
			titan_pkg::OPC_LOAD: begin
				dec_o.rs1 = id_instruction_i[19:15];
				dec_o.rd = id_instruction_i[11:7];
				dec_o.we = 1'b1;
				dec_o.imm = imm_i;
				dec_o.portb_sel_imm = 1'b1;
				dec_o.mem_flags.read = 1'b1;
				dec_o.mem_flags.uns = funct3[2];
				dec_o.mem_flags.size = mem_size(funct3[1:0]);
				illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			end
			titan_pkg::OPC_STORE: begin
				dec_o.rs1 = id_instruction_i[19:15];
				dec_o.rs2 = id_instruction_i[24:20];
				dec_o.imm = imm_s;
				dec_o.portb_sel_imm = 1'b1;
				dec_o.mem_flags.write = 1'b1;
				dec_o.mem_flags.size = mem_size(funct3[1:0]);
				illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			titan_pkg::OPC_OP_IMM: begin
				dec_o.rs1 = id_instruction_i[19:15];
				dec_o.rd = id_instruction_i[11:7];
				dec_o.we = 1'b1;
				dec_o.imm = imm_i;
				dec_o.portb_sel_imm = 1'b1;
				dec_o.shift_op = (funct3[1:0] == 2'b01);
				// addi ignores bit 30, only srai uses it
				dec_o.alu_op = alu_sel(funct3, (funct3 == 3'b101) && funct7[5]);
				illegal = dec_o.shift_op && (funct7 != 7'b0000000)
					&& !((funct3 == 3'b101) && (funct7 == 7'b0100000));
			end
			titan_pkg::OPC_OP: begin
				dec_o.rs1 = id_instruction_i[19:15];
				dec_o.rs2 = id_instruction_i[24:20];
				dec_o.rd = id_instruction_i[11:7];
				dec_o.we = 1'b1;
				dec_o.shift_op = (funct3[1:0] == 2'b01);
				dec_o.alu_op = alu_sel(funct3, funct7[5]);
				illegal = !((funct7 == 7'b0000000) || ((funct7 == 7'b0100000)
					&& ((funct3 == 3'b000) || (funct3 == 3'b101))));
			end
			default: illegal = 1'b1;
		endcase
		// illegal encodings never write back or touch memory
		if (illegal) begin
			dec_o.we = 1'b0;
			dec_o.mem_flags = '0;
			dec_o.branch_op = 1'b0;
			dec_o.jump_op = 1'b0;
			dec_o.jalr_op = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: id_stage/titan_id_stage.sv
`default_nettype none

`include "titan_defines.svh"

module titan_id_stage (
	input wire [`TITAN_XLEN-1:0]      id_pc_i,
	input wire [`TITAN_ILEN-1:0]      id_instruction_i,
	input wire [`TITAN_XLEN-1:0]      ex_fwd_drd_i,
	input wire [`TITAN_XLEN-1:0]      mem_fwd_drd_i,
	input wire [`TITAN_XLEN-1:0]      wb_fwd_drd_i,
	input wire [`TITAN_FWD_SEL_W-1:0] forward_a_sel_i,
	input wire [`TITAN_FWD_SEL_W-1:0] forward_b_sel_i,
	titan_rf_if.req                   rf_o,
	output logic [`TITAN_RADDR_W-1:0] id_rs1_o,
	output logic [`TITAN_RADDR_W-1:0] id_rs2_o,
	output logic [`TITAN_XLEN-1:0]    pc_branch_address_o,
	output logic [`TITAN_XLEN-1:0]    pc_jump_address_o,
	output logic                      take_branch_o,
	output logic                      take_jump_o,
	output logic                      id_illegal_inst_o,
	output titan_pkg::idex_t          idex_o
);

	logic [`TITAN_XLEN-1:0] opa;
	logic [`TITAN_XLEN-1:0] opb;
	logic [`TITAN_XLEN-1:0] jalr_sum;
	logic [`TITAN_XLEN-1:0] port_a;
	logic [`TITAN_XLEN-1:0] port_b_raw;
	logic [`TITAN_XLEN-1:0] port_b;
	logic                   cmp_true;

	function automatic logic [`TITAN_XLEN-1:0] fwd_pick(
		input logic [`TITAN_FWD_SEL_W-1:0] sel,
		input logic [`TITAN_XLEN-1:0]      rf_val,
		input logic [`TITAN_XLEN-1:0]      ex_val,
		input logic [`TITAN_XLEN-1:0]      mem_val,
		input logic [`TITAN_XLEN-1:0]      wb_val
	);
		case (sel)
			2'd0:    return rf_val;
			2'd1:    return ex_val;
			2'd2:    return mem_val;
			default: return wb_val;
		endcase
	endfunction

	titan_dec_if dec_bus ();

	titan_decoder u_decoder (
		.id_instruction_i(id_instruction_i),
		.dec_o           (dec_bus)
	);

	assign rf_o.raddr1 = dec_bus.rs1;
	assign rf_o.raddr2 = dec_bus.rs2;
	assign id_rs1_o = dec_bus.rs1;
	assign id_rs2_o = dec_bus.rs2;
	assign id_illegal_inst_o = dec_bus.illegal;

	assign opa = fwd_pick(forward_a_sel_i, rf_o.rdata1, ex_fwd_drd_i, mem_fwd_drd_i, wb_fwd_drd_i);
	assign opb = fwd_pick(forward_b_sel_i, rf_o.rdata2, ex_fwd_drd_i, mem_fwd_drd_i, wb_fwd_drd_i);

	always_comb begin
		case (dec_bus.cmp_op)
			titan_pkg::CMP_EQ:  cmp_true = (opa == opb);
			titan_pkg::CMP_NE:  cmp_true = (opa != opb);
			titan_pkg::CMP_LT:  cmp_true = ($signed(opa) < $signed(opb));
			titan_pkg::CMP_GE:  cmp_true = ($signed(opa) >= $signed(opb));
			titan_pkg::CMP_LTU: cmp_true = (opa < opb);
			titan_pkg::CMP_GEU: cmp_true = (opa >= opb);
			default:            cmp_true = 1'b0;
		endcase
	end

	assign take_branch_o = dec_bus.branch_op & cmp_true;
	assign take_jump_o = dec_bus.jump_op;

	// jal target shares the pc relative adder with branches
	assign pc_branch_address_o = id_pc_i + dec_bus.imm;
	assign jalr_sum = opa + dec_bus.imm;
	assign pc_jump_address_o = dec_bus.jalr_op ? {jalr_sum[`TITAN_XLEN-1:1], 1'b0}
		: pc_branch_address_o;

	// link value pc+4 goes out on port a for jumps
	assign port_a = !dec_bus.porta_sel_pc ? opa
		: (dec_bus.jump_op ? id_pc_i + `TITAN_LINK_OFFSET : id_pc_i);
	assign port_b_raw = dec_bus.portb_sel_imm ? dec_bus.imm : opb;
	assign port_b = dec_bus.shift_op
		? {{(`TITAN_XLEN-`TITAN_SHAMT_W){1'b0}}, port_b_raw[`TITAN_SHAMT_W-1:0]} : port_b_raw;

	always_comb begin
		idex_o.pc = id_pc_i;
		idex_o.instruction = id_instruction_i;
		idex_o.port_a = port_a;
		idex_o.port_b = port_b;
		idex_o.alu_op = dec_bus.alu_op;
		idex_o.waddr = dec_bus.rd;
		idex_o.we = dec_bus.we;
		idex_o.store_data = opb;
		idex_o.mem_flags = dec_bus.mem_flags;
		idex_o.illegal = dec_bus.illegal;
	end

endmodule

`default_nettype wire

// File: id_stage/titan_idex_register.sv
`default_nettype none

`include "titan_defines.svh"

module titan_idex_register (
	input wire                   clk_i,
	input wire                   rst_n_i,
	input wire                   ex_stall_i,
	input wire                   ex_flush_i,
	input var titan_pkg::idex_t  idex_i,
	output titan_pkg::idex_t     idex_o
);

	titan_pkg::idex_t bubble;
	titan_pkg::idex_t reset_val;

	// bubble is an all-zero nop, no write and no memory access
	always_comb begin
		bubble = '0;
		bubble.alu_op = titan_pkg::ALU_ADD;
		bubble.we = 1'b0;
		bubble.mem_flags = '0;
		bubble.illegal = 1'b0;
	end

	always_comb begin
		reset_val = bubble;
		reset_val.pc = `TITAN_RESET_PC;
	end

	// reset first, then flush over stall
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			idex_o <= reset_val;
		end else if (ex_flush_i) begin
			idex_o <= bubble;
		end else if (!ex_stall_i) begin
			idex_o <= idex_i;
		end
	end

endmodule

`default_nettype wire

// File: hw/titan_reg_file.sv
`default_nettype none

`include "titan_defines.svh"

module titan_reg_file (
	input wire                      clk_i,
	input wire [`TITAN_RADDR_W-1:0] wb_address_i,
	input wire [`TITAN_XLEN-1:0]    wb_data_i,
	input wire                      wb_we_i,
	titan_rf_if.rf                  rf_i
);

	// no storage behind x0
	logic [`TITAN_XLEN-1:0] regs [1:`TITAN_NREGS-1];

	always_ff @(posedge clk_i) begin
		if (wb_we_i && (wb_address_i != '0)) begin
			regs[wb_address_i] <= wb_data_i;
		end
	end

	// same-cycle write is not bypassed here, forward select 3 covers it
	always_comb begin
		if (rf_i.raddr1 == '0) begin
			rf_i.rdata1 = '0;
		end else begin
			rf_i.rdata1 = regs[rf_i.raddr1];
		end
		if (rf_i.raddr2 == '0) begin
			rf_i.rdata2 = '0;
		end else begin
			rf_i.rdata2 = regs[rf_i.raddr2];
		end
	end

endmodule

`default_nettype wire

// File: hw/titan_id_top.sv
`default_nettype none

`include "titan_defines.svh"

module titan_id_top (
	input wire                        clk_i,
	input wire                        rst_n_i,
	input wire                        ex_stall_i,
	input wire                        ex_flush_i,
	input wire [`TITAN_XLEN-1:0]      id_pc_i,
	input wire [`TITAN_ILEN-1:0]      id_instruction_i,
	input wire [`TITAN_XLEN-1:0]      wb_data_i,
	input wire [`TITAN_RADDR_W-1:0]   wb_address_i,
	input wire                        wb_we_i,
	input wire [`TITAN_XLEN-1:0]      ex_fwd_drd_i,
	input wire [`TITAN_XLEN-1:0]      mem_fwd_drd_i,
	input wire [`TITAN_XLEN-1:0]      wb_fwd_drd_i,
	input wire [`TITAN_FWD_SEL_W-1:0] forward_a_sel_i,
	input wire [`TITAN_FWD_SEL_W-1:0] forward_b_sel_i,
	output logic [`TITAN_RADDR_W-1:0] id_rs1_o,
	output logic [`TITAN_RADDR_W-1:0] id_rs2_o,
	output logic [`TITAN_XLEN-1:0]    pc_branch_address_o,
	output logic [`TITAN_XLEN-1:0]    pc_jump_address_o,
	output logic                      take_branch_o,
	output logic                      take_jump_o,
	output logic                      id_illegal_inst_o,
	output logic [`TITAN_XLEN-1:0]    ex_pc_o,
	output logic [`TITAN_ILEN-1:0]    ex_instruction_o,
	output logic [`TITAN_XLEN-1:0]    ex_port_a_o,
	output logic [`TITAN_XLEN-1:0]    ex_port_b_o,
	output logic [3:0]                ex_alu_op_o,
	output logic [`TITAN_RADDR_W-1:0] ex_waddr_o,
	output logic                      ex_we_o,
	output logic [`TITAN_XLEN-1:0]    ex_store_data_o,
	output logic [5:0]                ex_mem_flags_o,
	output logic                      ex_illegal_inst_o
);

	titan_pkg::idex_t id_payload;
	titan_pkg::idex_t ex_payload;

	titan_rf_if rf_bus ();

	titan_id_stage u_stage (
		.id_pc_i            (id_pc_i),
		.id_instruction_i   (id_instruction_i),
		.ex_fwd_drd_i       (ex_fwd_drd_i),
		.mem_fwd_drd_i      (mem_fwd_drd_i),
		.wb_fwd_drd_i       (wb_fwd_drd_i),
		.forward_a_sel_i    (forward_a_sel_i),
		.forward_b_sel_i    (forward_b_sel_i),
		.rf_o               (rf_bus),
		.id_rs1_o           (id_rs1_o),
		.id_rs2_o           (id_rs2_o),
		.pc_branch_address_o(pc_branch_address_o),
		.pc_jump_address_o  (pc_jump_address_o),
		.take_branch_o      (take_branch_o),
		.take_jump_o        (take_jump_o),
		.id_illegal_inst_o  (id_illegal_inst_o),
		.idex_o             (id_payload)
	);

	titan_reg_file u_reg_file (
		.clk_i       (clk_i),
		.wb_address_i(wb_address_i),
		.wb_data_i   (wb_data_i),
		.wb_we_i     (wb_we_i),
		.rf_i        (rf_bus)
	);

	titan_idex_register u_idex (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.ex_stall_i(ex_stall_i),
		.ex_flush_i(ex_flush_i),
		.idex_i    (id_payload),
		.idex_o    (ex_payload)
	);

	// execute side fields
	assign ex_pc_o = ex_payload.pc;
	assign ex_instruction_o = ex_payload.instruction;
	assign ex_port_a_o = ex_payload.port_a;
	assign ex_port_b_o = ex_payload.port_b;
	assign ex_alu_op_o = ex_payload.alu_op;
	assign ex_waddr_o = ex_payload.waddr;
	assign ex_we_o = ex_payload.we;
	assign ex_store_data_o = ex_payload.store_data;
	assign ex_mem_flags_o = ex_payload.mem_flags;
	assign ex_illegal_inst_o = ex_payload.illegal;

endmodule

`default_nettype wire

// File: verif/titan_tb_clkgen.sv
`default_nettype none

module titan_tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	// reset held low for the first four rising edges
	initial begin
		clk_o = 1'b0;
		rst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

	always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: verif/titan_id_tb.sv
`default_nettype none

`include "titan_defines.svh"

module titan_id_tb;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [1:0]  fa;
		logic [1:0]  fb;
		logic        stall;
		logic        flush;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] br;
		logic [31:0] jmp;
		logic        tb;
		logic        tj;
		logic        ill;
	} id_row_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] pa;
		logic [31:0] pb;
		logic [3:0]  alu;
		logic [4:0]  waddr;
		logic        we;
		logic [31:0] sd;
		logic [5:0]  mf;
		logic        ill;
	} ex_row_t;

	logic clk, rst_n, stall_r, flush_r, wb_we_r;
	logic [31:0] pc_r, instr_r, wb_data_r, fex, fmem, fwb;
	logic [4:0] wb_addr_r;
	logic [1:0] fa_r, fb_r;
	logic [4:0] id_rs1, id_rs2, ex_waddr;
	logic [31:0] br_addr, jmp_addr, ex_pc, ex_instr, ex_pa, ex_pb, ex_sd;
	logic take_br, take_jmp, id_ill, ex_we, ex_ill;
	logic [3:0] ex_alu;
	logic [5:0] ex_mf;
	logic [31:0] shadow [0:31];
	id_row_t id_tab [0:39];
	ex_row_t ex_tab [0:39];
	int nrows;
	int errors;
	integer seed;
	logic seen_reset;

	titan_tb_clkgen clkgen (.clk_o(clk), .rst_n_o(rst_n));

	titan_id_top uut (
		.clk_i(clk), .rst_n_i(rst_n), .ex_stall_i(stall_r), .ex_flush_i(flush_r),
		.id_pc_i(pc_r), .id_instruction_i(instr_r),
		.wb_data_i(wb_data_r), .wb_address_i(wb_addr_r), .wb_we_i(wb_we_r),
		.ex_fwd_drd_i(fex), .mem_fwd_drd_i(fmem), .wb_fwd_drd_i(fwb),
		.forward_a_sel_i(fa_r), .forward_b_sel_i(fb_r),
		.id_rs1_o(id_rs1), .id_rs2_o(id_rs2), .pc_branch_address_o(br_addr),
		.pc_jump_address_o(jmp_addr), .take_branch_o(take_br), .take_jump_o(take_jmp),
		.id_illegal_inst_o(id_ill), .ex_pc_o(ex_pc), .ex_instruction_o(ex_instr),
		.ex_port_a_o(ex_pa), .ex_port_b_o(ex_pb), .ex_alu_op_o(ex_alu),
		.ex_waddr_o(ex_waddr), .ex_we_o(ex_we), .ex_store_data_o(ex_sd),
		.ex_mem_flags_o(ex_mf), .ex_illegal_inst_o(ex_ill)
	);

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk);
		wb_we_r <= 1'b1;
		wb_addr_r <= addr;
		wb_data_r <= data;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	// ex side expectation follows stall hold and flush bubble rules
	task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
		input logic [1:0] fa, input logic [1:0] fb, input logic stall, input logic flush,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] br,
		input logic [31:0] jmp, input logic tb, input logic tj, input logic ill,
		input logic [31:0] pa, input logic [31:0] pb, input logic [3:0] alu,
		input logic [4:0] waddr, input logic we, input logic [31:0] sd, input logic [5:0] mf);
		ex_row_t e;
		id_tab[nrows] = '{instr, pc, fa, fb, stall, flush, rs1, rs2, br, jmp, tb, tj, ill};
		if (flush) begin
			e = '0;
		end else if (stall) begin
			e = (nrows > 0) ? ex_tab[nrows-1] : '0;
		end else begin
			e = '{pc, instr, pa, pb, alu, waddr, we, sd, mf, ill};
		end
		ex_tab[nrows] = e;
		nrows++;
	endtask

	// branch rows compare register values and point 16 bytes ahead
	task automatic add_branch(input logic [31:0] instr, input logic [31:0] pc,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic taken);
		add_row(instr, pc, 0, 0, 0, 0, rs1, rs2, pc + 32'd16, pc + 32'd16, taken, 0, 0,
			shadow[rs1], shadow[rs2], titan_pkg::ALU_ADD, 0, 0, shadow[rs2], 0);
	endtask

	task automatic check_id(input id_row_t r);
		compare("id_rs1", id_rs1, r.rs1);
		compare("id_rs2", id_rs2, r.rs2);
		compare("branch addr", br_addr, r.br);
		compare("jump addr", jmp_addr, r.jmp);
		compare("take_branch", take_br, r.tb);
		compare("take_jump", take_jmp, r.tj);
		compare("id_illegal", id_ill, r.ill);
	endtask

	task automatic check_ex(input ex_row_t e);
		compare("ex_pc", ex_pc, e.pc);
		compare("ex_instruction", ex_instr, e.instr);
		compare("ex_port_a", ex_pa, e.pa);
		compare("ex_port_b", ex_pb, e.pb);
		compare("ex_alu_op", ex_alu, e.alu);
		compare("ex_waddr", ex_waddr, e.waddr);
		compare("ex_we", ex_we, e.we);
		compare("ex_store_data", ex_sd, e.sd);
		compare("ex_mem_flags", ex_mf, e.mf);
		compare("ex_illegal", ex_ill, e.ill);
	endtask

	initial begin
		for (int c = 0; c < 3000; c++) begin
			@(posedge clk);
		end
		$display("simulation timed out before the table finished");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		nrows = 0;
		seed = 32'h49e4af60;
		seen_reset = 1'b0;
		stall_r = 1'b0;
		flush_r = 1'b0;
		wb_we_r = 1'b0;
		wb_addr_r = '0;
		wb_data_r = '0;
		pc_r = '0;
		instr_r = '0;
		fa_r = '0;
		fb_r = '0;
		fex = $random(seed);
		fmem = $random(seed);
		fwb = $random(seed);
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0;
		end
		for (int c = 0; c < 20 && !seen_reset; c++) begin
			@(negedge clk);
			seen_reset = rst_n;
		end
		if (!seen_reset) begin
			$display("reset was never released");
			$display("TEST FAILED");
			$finish;
		end else begin
			check_ex('0);
			write_reg(1, 32'd5);
			write_reg(2, 32'hffff_fffd);
			write_reg(3, 32'd5);
			write_reg(4, 32'h8000_0000);
			write_reg(5, 32'h1234_5678);
			write_reg(0, 32'hdead_beef);
			@(posedge clk);
			wb_we_r <= 1'b0;

			// sub, sra and srai with masked shift amounts, then addi
			add_row(32'h40208333, 32'h100, 0, 0, 0, 0, 1, 2, 32'h100, 32'h100, 0, 0, 0,
				shadow[1], shadow[2], titan_pkg::ALU_SUB, 6, 1, shadow[2], 0);
			add_row(32'h402253b3, 32'h104, 0, 0, 0, 0, 4, 2, 32'h104, 32'h104, 0, 0, 0,
				shadow[4], 32'h1d, titan_pkg::ALU_SRA, 7, 1, shadow[2], 0);
			add_row(32'h4042d413, 32'h108, 0, 0, 0, 0, 5, 0, 32'h50c, 32'h50c, 0, 0, 0,
				shadow[5], 32'd4, titan_pkg::ALU_SRA, 8, 1, 0, 0);
			add_row(32'hfff10493, 32'h10c, 0, 0, 0, 0, 2, 0, 32'h10b, 32'h10b, 0, 0, 0,
				shadow[2], 32'hffff_ffff, titan_pkg::ALU_ADD, 9, 1, 0, 0);
			// forwarding selects on both ports and x0 reads
			add_row(32'h00308533, 32'h110, 1, 2, 0, 0, 1, 3, 32'h110, 32'h110, 0, 0, 0,
				fex, fmem, titan_pkg::ALU_ADD, 10, 1, fmem, 0);
			add_row(32'h00308533, 32'h114, 3, 3, 0, 0, 1, 3, 32'h114, 32'h114, 0, 0, 0,
				fwb, fwb, titan_pkg::ALU_ADD, 10, 1, fwb, 0);
			add_row(32'h00308533, 32'h118, 2, 1, 0, 0, 1, 3, 32'h118, 32'h118, 0, 0, 0,
				fmem, fex, titan_pkg::ALU_ADD, 10, 1, fex, 0);
			add_row(32'h000005b3, 32'h11c, 0, 0, 0, 0, 0, 0, 32'h11c, 32'h11c, 0, 0, 0,
				0, 0, titan_pkg::ALU_ADD, 11, 1, 0, 0);
			add_branch(32'h00308863, 32'h200, 1, 3, 1);
			add_branch(32'h00208863, 32'h204, 1, 2, 0);
			add_branch(32'h00209863, 32'h208, 1, 2, 1);
			add_branch(32'h00309863, 32'h20c, 1, 3, 0);
			add_branch(32'h00114863, 32'h210, 2, 1, 1);
			add_branch(32'h0020c863, 32'h214, 1, 2, 0);
			add_branch(32'h0020d863, 32'h218, 1, 2, 1);
			add_branch(32'h00115863, 32'h21c, 2, 1, 0);
			add_branch(32'h0020e863, 32'h220, 1, 2, 1);
			add_branch(32'h00116863, 32'h224, 2, 1, 0);
			add_branch(32'h00117863, 32'h228, 2, 1, 1);
			add_branch(32'h0020f863, 32'h22c, 1, 2, 0);
			// jal and jalr with the link value on port a
			add_row(32'h0200066f, 32'h300, 0, 0, 0, 0, 0, 0, 32'h320, 32'h320, 0, 1, 0,
				32'h304, 0, titan_pkg::ALU_ADD, 12, 1, 0, 0);
			add_row(32'h003286e7, 32'h304, 0, 0, 0, 0, 5, 0, 32'h307, 32'h1234_567a, 0, 1, 0,
				32'h308, 0, titan_pkg::ALU_ADD, 13, 1, 0, 0);
			// lw, lbu and sh followed by two illegal encodings
			add_row(32'h0080a703, 32'h308, 0, 0, 0, 0, 1, 0, 32'h310, 32'h310, 0, 0, 0,
				shadow[1], 32'd8, titan_pkg::ALU_ADD, 14, 1, 0, 6'h24);
			add_row(32'hffc14783, 32'h30c, 0, 0, 0, 0, 2, 0, 32'h308, 32'h308, 0, 0, 0,
				shadow[2], 32'hffff_fffc, titan_pkg::ALU_ADD, 15, 1, 0, 6'h29);
			add_row(32'h00519323, 32'h310, 0, 0, 0, 0, 3, 5, 32'h316, 32'h316, 0, 0, 0,
				shadow[3], 32'd6, titan_pkg::ALU_ADD, 0, 0, shadow[5], 6'h12);
			add_row(32'hffffffff, 32'h314, 0, 0, 0, 0, 0, 0, 32'h314, 32'h314, 0, 0, 1,
				0, 0, titan_pkg::ALU_ADD, 0, 0, 0, 0);
			add_row(32'h02208333, 32'h318, 0, 0, 0, 0, 1, 2, 32'h318, 32'h318, 0, 0, 1,
				shadow[1], shadow[2], titan_pkg::ALU_ADD, 6, 0, shadow[2], 0);
			// lui, stalled auipc, flush with stall, flush alone, then auipc again
			add_row(32'h12345837, 32'h400, 0, 0, 0, 0, 0, 0, 32'h1234_5400, 32'h1234_5400,
				0, 0, 0, 0, 32'h1234_5000, titan_pkg::ALU_ADD, 16, 1, 0, 0);
			add_row(32'h00001897, 32'h404, 0, 0, 1, 0, 0, 0, 32'h1404, 32'h1404, 0, 0, 0,
				32'h404, 32'h1000, titan_pkg::ALU_ADD, 17, 1, 0, 0);
			add_row(32'hfff10493, 32'h408, 0, 0, 1, 1, 2, 0, 32'h407, 32'h407, 0, 0, 0,
				shadow[2], 32'hffff_ffff, titan_pkg::ALU_ADD, 9, 1, 0, 0);
			add_row(32'h40208333, 32'h40c, 0, 0, 0, 1, 1, 2, 32'h40c, 32'h40c, 0, 0, 0,
				shadow[1], shadow[2], titan_pkg::ALU_SUB, 6, 1, shadow[2], 0);
			add_row(32'h00001897, 32'h410, 0, 0, 0, 0, 0, 0, 32'h1410, 32'h1410, 0, 0, 0,
				32'h410, 32'h1000, titan_pkg::ALU_ADD, 17, 1, 0, 0);

			// ex results of a row show up one edge after its id checks
			for (int i = 0; i <= nrows; i++) begin
				@(posedge clk);
				if (i < nrows) begin
					instr_r <= id_tab[i].instr;
					pc_r <= id_tab[i].pc;
					fa_r <= id_tab[i].fa;
					fb_r <= id_tab[i].fb;
					stall_r <= id_tab[i].stall;
					flush_r <= id_tab[i].flush;
				end else begin
					stall_r <= 1'b0;
					flush_r <= 1'b0;
				end
				@(negedge clk);
				if (i < nrows) begin
					check_id(id_tab[i]);
				end
				if (i > 0) begin
					check_ex(ex_tab[i-1]);
				end
			end

			$display("rows: %0d, errors: %0d", nrows, errors);
			if (errors == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+common
common/titan_pkg.sv
common/titan_dec_if.sv
common/titan_rf_if.sv
id_stage/titan_decoder.sv
id_stage/titan_id_stage.sv
id_stage/titan_idex_register.sv
hw/titan_reg_file.sv
hw/titan_id_top.sv
verif/titan_tb_clkgen.sv
verif/titan_id_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module titan_id_tb \
	-o titan_id_sim > build.log 2>&1 \
	&& ./obj_dir/titan_id_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
